// ==== sys1_defines.svh ====
// System-1 cartridge loader constants
// rom geometry, download map, keyboard codes and game codes
`ifndef SYS1_DEFINES_SVH
`define SYS1_DEFINES_SVH

// bank address widths, words for main, bytes for sound
`define ROM0_AW 14
`define SLAP_AW 14
`define ROMX_AW 15
`define SROM_AW 14

// download map, index 0 byte addresses
`define REGION_ROM0  25'h100000
`define REGION_ROM1  25'h110000
`define REGION_ROM2  25'h120000
`define REGION_ROM5  25'h150000
`define REGION_ROM6  25'h160000
`define REGION_ROM7  25'h170000
`define REGION_SLAP  25'h180000
`define REGION_SROM0 25'h188000
`define REGION_SROM1 25'h18C000
`define REGION_SROM2 25'h190000

// ps2 codes, bit 8 is the extended prefix
`define KEY_P1_UP    9'h175
`define KEY_P1_DOWN  9'h172
`define KEY_P1_LEFT  9'h16B
`define KEY_P1_RIGHT 9'h174
`define KEY_P1_START 9'h014
`define KEY_P1_JUMP  9'h011
`define KEY_P2_UP    9'h02D
`define KEY_P2_DOWN  9'h02B
`define KEY_P2_LEFT  9'h023
`define KEY_P2_RIGHT 9'h034
`define KEY_P2_START 9'h01C
`define KEY_P2_JUMP  9'h01B
`define KEY_COIN_L   9'h02E
`define KEY_COIN_R   9'h036
`define KEY_COIN_AUX 9'h03D

// slapstic game codes
`define GAME_MARBLE 8'd103
`define GAME_INDY   8'd105
`define GAME_PETER  8'd107

`endif

// ==== sys1_pkg.sv ====
// System-1 loader types
// download byte, rom write, graphics write, cpu fetch and cabinet bundles
package sys1_pkg;

	// target of an index 0 download byte
	typedef enum logic [3:0] {
		NONE,
		ROM0,
		ROM1,
		ROM2,
		ROM5,
		ROM6,
		ROM7,
		SLAP,
		SROM0,
		SROM1,
		SROM2
	} rom_region_e;

	// one byte from the download port
	typedef struct packed {
		logic        wr;
		logic        download;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [7:0]  data;
	} dl_byte_t;

	// byte wide regions only use data[7:0]
	typedef struct packed {
		rom_region_e region;
		logic [14:0] addr;
		logic [15:0] data;
		logic        valid;
	} rom_wr_t;

	typedef struct packed {
		logic        valid;
		logic [22:0] addr;
		logic [31:0] data;
	} gfx_wr_t;

	// main cpu fetch, selects active low
	typedef struct packed {
		logic [4:0]  rom_n;
		logic        ma18_n;
		logic [14:0] madec;
	} main_rd_t;

	typedef struct packed {
		logic [2:0]  srom_n;
		logic [13:0] sba;
	} sound_rd_t;

	// coin_n is aux, right, left; p2_dir is UDLR
	typedef struct packed {
		logic [7:0] joy;
		logic [7:0] switches;
		logic [2:0] coin_n;
		logic [3:0] p2_dir;
		logic       selftest_n;
	} cab_ctrl_t;

endpackage

// ==== rom_bank.sv ====
// ROM bank
// simple dual port storage, download write side and registered cpu read side
`timescale 1ns/1ns

module rom_bank
#(
	parameter int AW = 14,
	parameter int DW = 16
)
(
	input  logic          clk_sys,
	input  logic          wr_en,
	input  logic [AW-1:0] wr_addr,
	input  logic [DW-1:0] wr_data,
	input  logic [AW-1:0] rd_addr,
	output logic [DW-1:0] rd_data
);

	logic [DW-1:0] mem [2**AW];

	// download side
	always_ff @(posedge clk_sys)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// cpu side, one cycle latency
	always_ff @(posedge clk_sys)
	begin
		rd_data <= mem[rd_addr];
	end

endmodule

// ==== rom_download_decoder.sv ====
// ROM download decoder
// packs the index 0 byte stream into word, byte and graphics dword writes
`timescale 1ns/1ns
`include "sys1_defines.svh"

module rom_download_decoder
(
	input  logic                clk_sys,
	input  logic                reset,
	input  sys1_pkg::dl_byte_t  dl,
	output sys1_pkg::rom_wr_t   rom_wr,
	output sys1_pkg::gfx_wr_t   gfx_wr
);

	logic                  dl_ok;
	logic [23:0]           acc;
	logic [24:0]           prev_addr;
	sys1_pkg::rom_region_e region;
	logic                  is_word;
	logic                  is_byte;

	// address map of the index 0 stream
	function automatic sys1_pkg::rom_region_e decode_region(input logic [24:0] a);
		sys1_pkg::rom_region_e r;
		r = sys1_pkg::NONE;
		if (a[24:15] == 10'(`REGION_ROM0 >> 15))
			r = sys1_pkg::ROM0;
		else if (a[24:16] == 9'(`REGION_ROM1 >> 16))
			r = sys1_pkg::ROM1;
		else if (a[24:16] == 9'(`REGION_ROM2 >> 16))
			r = sys1_pkg::ROM2;
		else if (a[24:16] == 9'(`REGION_ROM5 >> 16))
			r = sys1_pkg::ROM5;
		else if (a[24:16] == 9'(`REGION_ROM6 >> 16))
			r = sys1_pkg::ROM6;
		else if (a[24:16] == 9'(`REGION_ROM7 >> 16))
			r = sys1_pkg::ROM7;
		else if (a[24:15] == 10'(`REGION_SLAP >> 15))
			r = sys1_pkg::SLAP;
		else if (a[24:14] == 11'(`REGION_SROM0 >> 14))
			r = sys1_pkg::SROM0;
		else if (a[24:14] == 11'(`REGION_SROM1 >> 14))
			r = sys1_pkg::SROM1;
		else if (a[24:14] == 11'(`REGION_SROM2 >> 14))
			r = sys1_pkg::SROM2;
		return r;
	endfunction

	// only index 0 bytes feed the rom side
	assign dl_ok   = dl.wr && dl.download && (dl.index == 8'd0);
	assign region  = decode_region(dl.addr);
	assign is_word = region inside {sys1_pkg::ROM0, sys1_pkg::ROM1, sys1_pkg::ROM2,
		sys1_pkg::ROM5, sys1_pkg::ROM6, sys1_pkg::ROM7, sys1_pkg::SLAP};
	assign is_byte = region inside {sys1_pkg::SROM0, sys1_pkg::SROM1, sys1_pkg::SROM2};

	// ########################################################################
	// last three bytes with the oldest on top

	always_ff @(posedge clk_sys)
	begin
		if (dl_ok)
		begin
			acc       <= {acc[15:0], dl.data};
			prev_addr <= dl.addr;
		end
	end

	// ########################################################################
	// strobes

	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			rom_wr.valid <= 1'b0;
			gfx_wr.valid <= 1'b0;
		end
		else
		begin
			// word regions fire on the odd byte
			rom_wr.valid <= dl_ok && ((is_word && dl.addr[0]) || is_byte);
			gfx_wr.valid <= dl_ok && (dl.addr[1:0] == 2'b11);
		end
	end

	// payload held between strobes
	always_ff @(posedge clk_sys)
	begin
		if (dl_ok)
		begin
			rom_wr.region <= region;
			gfx_wr.addr   <= dl.addr[24:2];
			gfx_wr.data   <= {acc, dl.data};
			if (is_byte)
			begin
				rom_wr.addr <= {1'b0, dl.addr[13:0]};
				rom_wr.data <= {8'h00, dl.data};
			end
			else
			begin
				// 16K word regions never set bit 15 inside their window
				rom_wr.addr <= dl.addr[15:1];
				rom_wr.data <= {acc[7:0], dl.data};
			end
		end
	end

	// a graphics dword closes on the byte right after the one before it
	a_gfx_after_byte: assert property (@(posedge clk_sys) disable iff (reset)
		gfx_wr.valid |-> $past(dl_ok && (dl.addr == prev_addr + 25'd1)));

endmodule

// ==== cart_rom_map.sv ====
// Cartridge ROM map
// holds every main and sound ROM bank and muxes cpu reads by chip select
`timescale 1ns/1ns
`include "sys1_defines.svh"

module cart_rom_map
(
	input  logic                clk_sys,
	input  logic                reset,
	input  sys1_pkg::rom_wr_t   rom_wr,
	input  sys1_pkg::main_rd_t  main_rd,
	input  sys1_pkg::sound_rd_t sound_rd,
	output logic [15:0]         main_data,
	output logic [7:0]          sound_data
);

	logic [15:0] rom0_q, rom1_q, rom2_q, rom5_q, rom6_q, rom7_q, slap_q;
	logic [7:0]  srom0_q, srom1_q, srom2_q;
	logic [4:0]  rom_n_q;
	logic        ma18_n_q;
	logic [2:0]  srom_n_q;

	// write enables by region
	function automatic logic hit(input sys1_pkg::rom_region_e r);
		return rom_wr.valid && (rom_wr.region == r);
	endfunction

	// ########################################################################
	// main cpu banks

	rom_bank #(.AW(`ROM0_AW), .DW(16)) u_rom0 (.clk_sys(clk_sys),
		.wr_en(hit(sys1_pkg::ROM0)), .wr_addr(rom_wr.addr[`ROM0_AW-1:0]),
		.wr_data(rom_wr.data), .rd_addr(main_rd.madec[`ROM0_AW-1:0]), .rd_data(rom0_q));
	rom_bank #(.AW(`ROMX_AW), .DW(16)) u_rom1 (.clk_sys(clk_sys),
		.wr_en(hit(sys1_pkg::ROM1)), .wr_addr(rom_wr.addr),
		.wr_data(rom_wr.data), .rd_addr(main_rd.madec), .rd_data(rom1_q));
	rom_bank #(.AW(`ROMX_AW), .DW(16)) u_rom2 (.clk_sys(clk_sys),
		.wr_en(hit(sys1_pkg::ROM2)), .wr_addr(rom_wr.addr),
		.wr_data(rom_wr.data), .rd_addr(main_rd.madec), .rd_data(rom2_q));
	rom_bank #(.AW(`ROMX_AW), .DW(16)) u_rom5 (.clk_sys(clk_sys),
		.wr_en(hit(sys1_pkg::ROM5)), .wr_addr(rom_wr.addr),
		.wr_data(rom_wr.data), .rd_addr(main_rd.madec), .rd_data(rom5_q));
	rom_bank #(.AW(`ROMX_AW), .DW(16)) u_rom6 (.clk_sys(clk_sys),
		.wr_en(hit(sys1_pkg::ROM6)), .wr_addr(rom_wr.addr),
		.wr_data(rom_wr.data), .rd_addr(main_rd.madec), .rd_data(rom6_q));
	// also stands in for ROM3, Indy only uses that one and never ROM7
	rom_bank #(.AW(`ROMX_AW), .DW(16)) u_rom7 (.clk_sys(clk_sys),
		.wr_en(hit(sys1_pkg::ROM7)), .wr_addr(rom_wr.addr),
		.wr_data(rom_wr.data), .rd_addr(main_rd.madec), .rd_data(rom7_q));
	rom_bank #(.AW(`SLAP_AW), .DW(16)) u_slap (.clk_sys(clk_sys),
		.wr_en(hit(sys1_pkg::SLAP)), .wr_addr(rom_wr.addr[`SLAP_AW-1:0]),
		.wr_data(rom_wr.data), .rd_addr(main_rd.madec[`SLAP_AW-1:0]), .rd_data(slap_q));

	// ########################################################################
	// sound cpu banks, byte wide

	rom_bank #(.AW(`SROM_AW), .DW(8)) u_srom0 (.clk_sys(clk_sys),
		.wr_en(hit(sys1_pkg::SROM0)), .wr_addr(rom_wr.addr[`SROM_AW-1:0]),
		.wr_data(rom_wr.data[7:0]), .rd_addr(sound_rd.sba), .rd_data(srom0_q));
	rom_bank #(.AW(`SROM_AW), .DW(8)) u_srom1 (.clk_sys(clk_sys),
		.wr_en(hit(sys1_pkg::SROM1)), .wr_addr(rom_wr.addr[`SROM_AW-1:0]),
		.wr_data(rom_wr.data[7:0]), .rd_addr(sound_rd.sba), .rd_data(srom1_q));
	rom_bank #(.AW(`SROM_AW), .DW(8)) u_srom2 (.clk_sys(clk_sys),
		.wr_en(hit(sys1_pkg::SROM2)), .wr_addr(rom_wr.addr[`SROM_AW-1:0]),
		.wr_data(rom_wr.data[7:0]), .rd_addr(sound_rd.sba), .rd_data(srom2_q));

	// selects delayed to line up with bank data
	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			rom_n_q  <= '1;
			ma18_n_q <= 1'b1;
			srom_n_q <= '1;
		end
		else
		begin
			rom_n_q  <= main_rd.rom_n;
			ma18_n_q <= main_rd.ma18_n;
			srom_n_q <= sound_rd.srom_n;
		end
	end

	// priority order matches the board decode
	always_comb
	begin
		if (!rom_n_q[0] && ma18_n_q)
			main_data = rom0_q;
		else if (!rom_n_q[1] && ma18_n_q)
			main_data = rom1_q;
		else if (!rom_n_q[2] && ma18_n_q)
			main_data = rom2_q;
		else if (!rom_n_q[3])
			main_data = rom7_q;
		else if (!rom_n_q[1])
			main_data = rom5_q;
		else if (!rom_n_q[2])
			main_data = rom6_q;
		else if (!rom_n_q[4])
			main_data = slap_q;
		else
			main_data = 16'h0000;
	end

	always_comb
	begin
		if (!srom_n_q[0])
			sound_data = srom0_q;
		else if (!srom_n_q[1])
			sound_data = srom1_q;
		else if (!srom_n_q[2])
			sound_data = srom2_q;
		else
			sound_data = 8'h00;
	end

	// the decoder never strobes an unmapped byte
	a_region_mapped: assert property (@(posedge clk_sys) disable iff (reset)
		rom_wr.valid |-> (rom_wr.region != sys1_pkg::NONE));

endmodule

// ==== cabinet_controls.sv ====
// Cabinet controls
// game type register, keyboard to player mapping and cabinet input layout
`timescale 1ns/1ns
`include "sys1_defines.svh"

module cabinet_controls
(
	input  logic                clk_sys,
	input  logic                reset,
	input  sys1_pkg::dl_byte_t  dl,
	input  logic [10:0]         ps2_key,
	input  logic [31:0]         joystick,
	input  logic                service,
	output sys1_pkg::cab_ctrl_t cab
);

	logic [7:0] game_type;
	logic       old_toggle;
	logic       pressed;
	logic [3:0] p1_dir, p2_dir;
	logic       p1_start, p1_jump, p2_start, p2_jump;
	logic       coin_l, coin_r, coin_aux;
	logic [3:0] dirs;
	logic       jump, start;

	assign pressed = ps2_key[9];

	// index 1 download carries the slapstic type
	always_ff @(posedge clk_sys)
	begin
		if (reset)
			game_type <= `GAME_INDY;
		else if (dl.wr && dl.download && (dl.index == 8'd1))
			game_type <= dl.data;
	end

	// ########################################################################
	// key events, one per toggle of bit 10

	always_ff @(posedge clk_sys)
	begin
		old_toggle <= ps2_key[10];
		if (reset)
		begin
			{p1_dir, p1_start, p1_jump} <= '0;
			{p2_dir, p2_start, p2_jump} <= '0;
			{coin_l, coin_r, coin_aux}  <= '0;
		end
		else if (old_toggle != ps2_key[10])
		begin
			case (ps2_key[8:0])
				`KEY_P1_UP:    p1_dir[3] <= pressed;
				`KEY_P1_DOWN:  p1_dir[2] <= pressed;
				`KEY_P1_LEFT:  p1_dir[1] <= pressed;
				`KEY_P1_RIGHT: p1_dir[0] <= pressed;
				`KEY_P1_START: p1_start  <= pressed;
				`KEY_P1_JUMP:  p1_jump   <= pressed;
				`KEY_P2_UP:    p2_dir[3] <= pressed;
				`KEY_P2_DOWN:  p2_dir[2] <= pressed;
				`KEY_P2_LEFT:  p2_dir[1] <= pressed;
				`KEY_P2_RIGHT: p2_dir[0] <= pressed;
				`KEY_P2_START: p2_start  <= pressed;
				`KEY_P2_JUMP:  p2_jump   <= pressed;
				`KEY_COIN_L:   coin_l    <= pressed;
				`KEY_COIN_R:   coin_r    <= pressed;
				`KEY_COIN_AUX: coin_aux  <= pressed;
				default:       ;
			endcase
		end
	end

	// action buttons are shared, either player may press them
	assign dirs  = p1_dir | joystick[3:0];
	assign jump  = p1_jump | p2_jump | joystick[4];
	assign start = p1_start | p2_start | joystick[5];

	// ########################################################################
	// cabinet layout per game

	always_comb
	begin
		// Indy shifts the stick up one bit
		if (game_type == `GAME_INDY)
			cab.joy = {3'b000, dirs, 1'b0};
		else
			cab.joy = {4'b0000, dirs};
		// Peter Pack Rat puts jump and throw either side of an open input
		if (game_type == `GAME_PETER)
			cab.switches = {3'b111, 2'b11, ~jump, 1'b1, ~start};
		else
			cab.switches = {3'b111, 3'b111, ~jump, ~start};
		cab.coin_n     = {~coin_aux, ~coin_r, ~(coin_l | joystick[8])};
		cab.p2_dir     = p2_dir;
		cab.selftest_n = ~service;
	end

endmodule

// ==== sys1_loader_top.sv ====
// System-1 loader top
// download decode, cartridge ROM banks and cabinet controls
`timescale 1ns/1ns

module sys1_loader_top
(
	input  logic                clk_sys,
	input  logic                reset,
	input  sys1_pkg::dl_byte_t  dl,
	input  logic [10:0]         ps2_key,
	input  logic [31:0]         joystick,
	input  logic                service,
	input  sys1_pkg::main_rd_t  main_rd,
	input  sys1_pkg::sound_rd_t sound_rd,
	output logic [15:0]         main_data,
	output logic [7:0]          sound_data,
	output sys1_pkg::gfx_wr_t   gfx_wr,
	output sys1_pkg::cab_ctrl_t cab
);

	// decoder to rom map
	sys1_pkg::rom_wr_t rom_wr;

	rom_download_decoder u_decoder
	(
		.clk_sys (clk_sys),
		.reset   (reset),
		.dl      (dl),
		.rom_wr  (rom_wr),
		.gfx_wr  (gfx_wr)
	);

	cart_rom_map u_rom_map
	(
		.clk_sys    (clk_sys),
		.reset      (reset),
		.rom_wr     (rom_wr),
		.main_rd    (main_rd),
		.sound_rd   (sound_rd),
		.main_data  (main_data),
		.sound_data (sound_data)
	);

	cabinet_controls u_controls
	(
		.clk_sys  (clk_sys),
		.reset    (reset),
		.dl       (dl),
		.ps2_key  (ps2_key),
		.joystick (joystick),
		.service  (service),
		.cab      (cab)
	);

endmodule

// ==== sys1_checker.sv ====
// System-1 loader checker
// compares DUT outputs with the model at the falling edge and counts errors
`timescale 1ns/1ns

module sys1_checker
(
	input  logic                clk_sys,
	input  logic                reset,
	input  logic [15:0]         main_data,
	input  logic [7:0]          sound_data,
	input  sys1_pkg::gfx_wr_t   gfx_wr,
	input  sys1_pkg::cab_ctrl_t cab,
	input  logic [15:0]         exp_main,
	input  logic                exp_main_en,
	input  logic [7:0]          exp_sound,
	input  logic                exp_sound_en,
	input  sys1_pkg::gfx_wr_t   exp_gfx,
	input  sys1_pkg::cab_ctrl_t exp_cab,
	output int                  errors,
	output int                  checks
);

	initial
	begin
		errors = 0;
		checks = 0;
	end

	// outputs settle after the rising edge
	always @(negedge clk_sys)
	begin
		if (!reset)
		begin
			// ##################################################################
			// rom reads, only where the model knows the word
			if (exp_main_en)
			begin
				checks++;
				if (main_data !== exp_main)
				begin
					errors++;
					$display("FAILED %0t: main_data %h, expected %h", $time, main_data,
						exp_main);
				end
			end
			if (exp_sound_en)
			begin
				checks++;
				if (sound_data !== exp_sound)
				begin
					errors++;
					$display("FAILED %0t: sound_data %h, expected %h", $time, sound_data,
						exp_sound);
				end
			end
			// graphics strobe every cycle, payload only with the strobe
			checks++;
			if (gfx_wr.valid !== exp_gfx.valid ||
				(exp_gfx.valid && (gfx_wr.addr !== exp_gfx.addr ||
				gfx_wr.data !== exp_gfx.data)))
			begin
				errors++;
				$display("FAILED %0t: gfx_wr %b %h %h, expected %b %h %h", $time,
					gfx_wr.valid, gfx_wr.addr, gfx_wr.data, exp_gfx.valid, exp_gfx.addr,
					exp_gfx.data);
			end
			// cabinet inputs
			checks++;
			if (cab !== exp_cab)
			begin
				errors++;
				$display("FAILED %0t: cab %h, expected %h", $time, cab, exp_cab);
			end
		end
	end

endmodule

// ==== tb_sys1_loader.sv ====
// System-1 loader testbench
// random downloads, cpu reads and key events against a behavioural model
`timescale 1ns/1ns
`include "sys1_defines.svh"

module tb_sys1_loader;

	localparam int N_GROUPS = 400;
	localparam int N_READS  = 1500;
	localparam int N_KEYS   = 1200;
	// each group is four bytes plus at most one game byte
	localparam int LIMIT    = 16 + N_GROUPS * 5 + N_READS + N_KEYS + 16 + 1000;

	logic                clk_sys;
	logic                reset;
	sys1_pkg::dl_byte_t  dl;
	logic [10:0]         ps2_key;
	logic [31:0]         joystick;
	logic                service;
	sys1_pkg::main_rd_t  main_rd;
	sys1_pkg::sound_rd_t sound_rd;
	logic [15:0]         main_data;
	logic [7:0]          sound_data;
	sys1_pkg::gfx_wr_t   gfx_wr;
	sys1_pkg::cab_ctrl_t cab;

	// rom image of the model keyed by download address
	bit [7:0]    rom_img [int];
	logic [24:0] grp_addr [$];
	int          grp_reg [$];
	logic [23:0] hist;

	// _d follows the stimulus and _q lines up with the DUT
	logic [14:0]         keys_d, keys_q;
	logic [7:0]          game_d, game_q;
	logic [15:0]         exp_main_d, exp_main_q;
	logic                exp_main_en_d, exp_main_en_q;
	logic [7:0]          exp_sound_d, exp_sound_q;
	logic                exp_sound_en_d, exp_sound_en_q;
	sys1_pkg::gfx_wr_t   exp_gfx_d, exp_gfx_q;
	sys1_pkg::cab_ctrl_t exp_cab;
	logic [3:0]          exp_dirs;
	logic                exp_jump, exp_start;
	int                  cycles, errors, checks;

	sys1_loader_top dut0 (.clk_sys(clk_sys), .reset(reset), .dl(dl), .ps2_key(ps2_key),
		.joystick(joystick), .service(service), .main_rd(main_rd), .sound_rd(sound_rd),
		.main_data(main_data), .sound_data(sound_data), .gfx_wr(gfx_wr), .cab(cab));

	sys1_checker u_checker (.clk_sys(clk_sys), .reset(reset), .main_data(main_data),
		.sound_data(sound_data), .gfx_wr(gfx_wr), .cab(cab), .exp_main(exp_main_q),
		.exp_main_en(exp_main_en_q), .exp_sound(exp_sound_q), .exp_sound_en(exp_sound_en_q),
		.exp_gfx(exp_gfx_q), .exp_cab(exp_cab), .errors(errors), .checks(checks));

	initial
	begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// ##########################################################################
	// reference model

	always @(posedge clk_sys)
	begin
		keys_q         <= keys_d;
		game_q         <= game_d;
		exp_main_q     <= exp_main_d;
		exp_main_en_q  <= exp_main_en_d;
		exp_sound_q    <= exp_sound_d;
		exp_sound_en_q <= exp_sound_en_d;
		exp_gfx_q      <= exp_gfx_d;
	end

	// key bits run p1 U D L R start jump then p2 U D L R start jump then coin L R aux
	always_comb
	begin
		exp_dirs  = {keys_q[0], keys_q[1], keys_q[2], keys_q[3]} | joystick[3:0];
		exp_jump  = keys_q[5] | keys_q[11] | joystick[4];
		exp_start = keys_q[4] | keys_q[10] | joystick[5];
		exp_cab.joy = (game_q == `GAME_INDY) ? {3'b000, exp_dirs, 1'b0} : {4'b0000, exp_dirs};
		exp_cab.switches = (game_q == `GAME_PETER) ?
			{5'b11111, ~exp_jump, 1'b1, ~exp_start} : {6'b111111, ~exp_jump, ~exp_start};
		exp_cab.coin_n     = {~keys_q[14], ~keys_q[13], ~(keys_q[12] | joystick[8])};
		exp_cab.p2_dir     = {keys_q[6], keys_q[7], keys_q[8], keys_q[9]};
		exp_cab.selftest_n = ~service;
	end

	// region index 0..9 runs ROM0 ROM1 ROM2 ROM5 ROM6 ROM7 SLAP SROM0 SROM1 SROM2
	function automatic logic [24:0] region_base(input int r);
		case (r)
			0: return `REGION_ROM0;
			1: return `REGION_ROM1;
			2: return `REGION_ROM2;
			3: return `REGION_ROM5;
			4: return `REGION_ROM6;
			5: return `REGION_ROM7;
			6: return `REGION_SLAP;
			7: return `REGION_SROM0;
			8: return `REGION_SROM1;
			default: return `REGION_SROM2;
		endcase
	endfunction

	// dword aligned offsets inside each window
	function automatic logic [24:0] offset_mask(input int r);
		if (r == 0 || r == 6)
			return 25'h7FFC;
		else if (r < 6)
			return 25'hFFFC;
		return 25'h3FFC;
	endfunction

	function automatic logic [8:0] key_code(input int i);
		case (i)
			0: return `KEY_P1_UP;
			1: return `KEY_P1_DOWN;
			2: return `KEY_P1_LEFT;
			3: return `KEY_P1_RIGHT;
			4: return `KEY_P1_START;
			5: return `KEY_P1_JUMP;
			6: return `KEY_P2_UP;
			7: return `KEY_P2_DOWN;
			8: return `KEY_P2_LEFT;
			9: return `KEY_P2_RIGHT;
			10: return `KEY_P2_START;
			11: return `KEY_P2_JUMP;
			12: return `KEY_COIN_L;
			13: return `KEY_COIN_R;
			14: return `KEY_COIN_AUX;
			// a code outside the table
			default: return 9'h05A;
		endcase
	endfunction

	function automatic logic [7:0] game_pick();
		case ($urandom % 3)
			0: return `GAME_MARBLE;
			1: return `GAME_INDY;
			default: return `GAME_PETER;
		endcase
	endfunction

	// board priority runs ROM0..2 in the high half then ROM7 then ROM5..6 then slapstic
	function automatic int main_pick(input logic [4:0] rom_n, input logic ma18_n);
		if (!rom_n[0] && ma18_n)
			return 0;
		else if (!rom_n[1] && ma18_n)
			return 1;
		else if (!rom_n[2] && ma18_n)
			return 2;
		else if (!rom_n[3])
			return 5;
		else if (!rom_n[1])
			return 3;
		else if (!rom_n[2])
			return 4;
		else if (!rom_n[4])
			return 6;
		return -1;
	endfunction

	// ##########################################################################
	// stimulus

	task automatic send_byte(input logic [7:0] index, input logic [24:0] addr,
		input logic [7:0] data);
		sys1_pkg::gfx_wr_t g;
		g = '0;
		@(posedge clk_sys);
		dl <= {1'b1, 1'b1, index, addr, data};
		if (index == 8'd0)
		begin
			rom_img[int'(addr)] = data;
			if (addr[1:0] == 2'b11)
			begin
				g.valid = 1'b1;
				g.addr  = addr[24:2];
				g.data  = {hist, data};
			end
			hist = {hist[15:0], data};
		end
		else
			game_d <= data;
		exp_gfx_d <= g;
	endtask

	task automatic idle_cycle();
		@(posedge clk_sys);
		dl        <= '0;
		exp_gfx_d <= '0;
	endtask

	task automatic download_group();
		int          r;
		logic [24:0] a;
		r = int'($urandom % 10);
		a = region_base(r) + (25'($urandom) & offset_mask(r));
		for (int b = 0; b < 4; b++)
			send_byte(8'd0, a + 25'(b), 8'($urandom));
		grp_addr.push_back(a);
		grp_reg.push_back(r);
		// game bytes aimed at the fresh group must leave the roms alone
		if ($urandom % 4 == 0)
			send_byte(8'd1, a + 25'($urandom % 4), game_pick());
	endtask

	task automatic expect_main(input sys1_pkg::main_rd_t m);
		int          w;
		logic [24:0] a;
		w = main_pick(m.rom_n, m.ma18_n);
		if (w == 0 || w == 6)
			a = region_base(w) + 25'({m.madec[13:0], 1'b0});
		else
			a = region_base(w) + 25'({m.madec, 1'b0});
		exp_main_en_d <= 1'b1;
		exp_main_d    <= 16'h0000;
		if (w >= 0)
		begin
			if (rom_img.exists(int'(a)) && rom_img.exists(int'(a + 25'd1)))
				exp_main_d <= {rom_img[int'(a)], rom_img[int'(a + 25'd1)]};
			else
				exp_main_en_d <= 1'b0;
		end
	endtask

	task automatic expect_sound(input sys1_pkg::sound_rd_t s);
		int          w;
		logic [24:0] a;
		w = !s.srom_n[0] ? 7 : !s.srom_n[1] ? 8 : !s.srom_n[2] ? 9 : -1;
		a = region_base(w) + 25'(s.sba);
		exp_sound_en_d <= 1'b1;
		exp_sound_d    <= 8'h00;
		if (w >= 0)
		begin
			if (rom_img.exists(int'(a)))
				exp_sound_d <= rom_img[int'(a)];
			else
				exp_sound_en_d <= 1'b0;
		end
	endtask

	task automatic read_cycle();
		int                  i, r;
		logic [24:0]         a;
		sys1_pkg::main_rd_t  m;
		sys1_pkg::sound_rd_t s;
		i = int'($urandom % grp_addr.size());
		r = grp_reg[i];
		a = grp_addr[i] + 25'({$urandom % 2, 1'b0});
		m = {5'($urandom), 1'($urandom), 15'($urandom)};
		s = {3'($urandom), 14'($urandom)};
		if ($urandom % 4 == 0)
			m.rom_n = 5'h1F;
		// half the time aim the select at the bank holding the word
		if (r < 7 && ($urandom % 2 == 0))
		begin
			m.madec = a[15:1];
			m.rom_n = ~(5'b00001 << ((r == 3) ? 1 : (r == 4) ? 2 : (r == 5) ? 3 :
				(r == 6) ? 4 : r));
			// other selects now and then compete through the priority order
			if ($urandom % 2 == 0)
				m.rom_n = m.rom_n & 5'($urandom);
			if (r <= 2)
				m.ma18_n = 1'b1;
			else if (r <= 4)
				m.ma18_n = 1'b0;
		end
		else if (r >= 7)
		begin
			s.sba    = a[13:0] + 14'($urandom % 4);
			s.srom_n = ~(3'b001 << (r - 7));
		end
		@(posedge clk_sys);
		main_rd  <= m;
		sound_rd <= s;
		expect_main(m);
		expect_sound(s);
	endtask

	task automatic key_step();
		int   i;
		logic p, tog;
		logic [7:0] g;
		i   = int'($urandom % 16);
		p   = 1'($urandom);
		tog = ($urandom % 8) != 0;
		g   = game_pick();
		@(posedge clk_sys);
		ps2_key <= {tog ? ~ps2_key[10] : ps2_key[10], p, key_code(i)};
		if (tog && i < 15)
			keys_d[i] <= p;
		if ($urandom % 8 == 0)
		begin
			joystick <= $urandom & 32'h0000013F;
			service  <= 1'($urandom);
		end
		dl <= '0;
		if ($urandom % 16 == 0)
		begin
			dl     <= {1'b1, 1'b1, 8'd1, 25'($urandom), g};
			game_d <= g;
		end
	endtask

	// ##########################################################################
	// run

	always @(posedge clk_sys)
	begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT)
		begin
			$display("timeout, run still busy after %0d cycles", LIMIT);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	initial
	begin
		void'($urandom(32'hbd8d));
		reset    = 1'b1;
		dl       = '0;
		ps2_key  = '0;
		joystick = '0;
		service  = 1'b0;
		main_rd  = {5'h1F, 1'b1, 15'h0000};
		sound_rd = {3'h7, 14'h0000};
		cycles   = 0;
		hist     = '0;
		keys_d   = '0;
		keys_q   = '0;
		game_d   = `GAME_INDY;
		game_q   = `GAME_INDY;
		{exp_main_d, exp_main_en_d, exp_sound_d, exp_sound_en_d, exp_gfx_d} = '0;
		{exp_main_q, exp_main_en_q, exp_sound_q, exp_sound_en_q, exp_gfx_q} = '0;
		repeat (16) @(posedge clk_sys);
		reset <= 1'b0;
		idle_cycle();
		for (int n = 0; n < N_GROUPS; n++)
			download_group();
		idle_cycle();
		for (int n = 0; n < N_READS; n++)
			read_cycle();
		@(posedge clk_sys);
		exp_main_en_d  <= 1'b0;
		exp_sound_en_d <= 1'b0;
		for (int n = 0; n < N_KEYS; n++)
			key_step();
		idle_cycle();
		repeat (4) @(posedge clk_sys);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+.
sys1_pkg.sv
rom_bank.sv
rom_download_decoder.sv
cart_rom_map.sv
cabinet_controls.sv
sys1_loader_top.sv
sys1_checker.sv
tb_sys1_loader.sv

// ==== run.sh ====
#!/bin/sh
# build and run the System-1 loader testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_sys1_loader -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

if echo "$out" | grep -q "ALL TESTS PASSED"; then
	exit 0
else
	exit 1
fi
